// ==== natv_params.svh ====
// native bus subsystem constants
// address map, register offsets, widths, unmapped read value

`ifndef NATV_PARAMS_SVH
`define NATV_PARAMS_SVH

// bus widths
`define NATV_ADDR_W 32
`define NATV_DATA_W 32
`define NATV_STRB_W 4

// address map, region in [31:24], slot in [15:8]
`define NATV_REG_REGION 8'h10
`define NATV_GPIO_SLOT 8'h00
`define NATV_TIM0_SLOT 8'h20
`define NATV_TIM1_SLOT 8'h30

`define NATV_GPIO_W 8

// gpio register offsets
`define NATV_GPIO_DIR 8'h00
`define NATV_GPIO_OUT 8'h04
`define NATV_GPIO_IN 8'h08

// timer register offsets
`define NATV_TIM_CTRL 8'h00
`define NATV_TIM_PSC 8'h04
`define NATV_TIM_CMP 8'h08
`define NATV_TIM_CNT 8'h0C
`define NATV_TIM_STAT 8'h10

`define NATV_UNMAPPED_RDATA 32'hDEAD_BEEF

`endif

// ==== natv_pkg.sv ====
// native bus types: address, data and byte strobes
// byte-strobe merge helper for register writes

`default_nettype none

`include "natv_params.svh"

package natv_pkg;

  // byte address of an access
  typedef logic [`NATV_ADDR_W-1:0] natv_addr_t;

  // write and read data
  typedef logic [`NATV_DATA_W-1:0] natv_data_t;

  // byte write strobes, all zero is a read
  typedef logic [`NATV_STRB_W-1:0] natv_strb_t;

  // replace the strobed bytes of a register value
  function automatic natv_data_t natv_strb_merge(
    input natv_data_t old_v,
    input natv_data_t new_v,
    input natv_strb_t strb
  );
    natv_data_t res;
    res = old_v;
    for (int i = 0; i < `NATV_STRB_W; i++) begin
      if (strb[i]) begin
        res[i*8+:8] = new_v[i*8+:8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== natv_decode.sv ====
// address decoder for the native bus
// one valid per peripheral slot plus a miss valid

`timescale 1ns/100ps
`default_nettype none

`include "natv_params.svh"

module natv_decode (
  input  logic                 nmi_valid_i,
  input  natv_pkg::natv_addr_t nmi_addr_i,
  output logic                 gpio_valid_o,
  output logic                 tim0_valid_o,
  output logic                 tim1_valid_o,
  output logic                 miss_valid_o
);

  logic       s_reg_region;
  logic [7:0] s_slot;
  logic       s_gpio_hit;
  logic       s_tim0_hit;
  logic       s_tim1_hit;
  logic       s_any_hit;

  // register space lives in one 16 MB region
  assign s_reg_region = nmi_addr_i[31:24] == `NATV_REG_REGION;
  assign s_slot       = nmi_addr_i[15:8];

  assign s_gpio_hit = s_reg_region && (s_slot == `NATV_GPIO_SLOT);
  assign s_tim0_hit = s_reg_region && (s_slot == `NATV_TIM0_SLOT);
  assign s_tim1_hit = s_reg_region && (s_slot == `NATV_TIM1_SLOT);
  assign s_any_hit  = s_gpio_hit | s_tim0_hit | s_tim1_hit;

  assign gpio_valid_o = nmi_valid_i & s_gpio_hit;
  assign tim0_valid_o = nmi_valid_i & s_tim0_hit;
  assign tim1_valid_o = nmi_valid_i & s_tim1_hit;

  // other regions and unused slots still get an answer
  assign miss_valid_o = nmi_valid_i & ~s_any_hit;

endmodule

`default_nettype wire

// ==== natv_gpio.sv ====
// gpio register block on the native bus
// DIR and OUT registers with byte strobes, read-only IN
// two-flop input synchronizer, output enable from DIR

`timescale 1ns/100ps
`default_nettype none

`include "natv_params.svh"

module natv_gpio (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    valid_i,
  input  natv_pkg::natv_addr_t    addr_i,
  input  natv_pkg::natv_data_t    wdata_i,
  input  natv_pkg::natv_strb_t    wstrb_i,
  output logic                    ready_o,
  output natv_pkg::natv_data_t    rdata_o,
  input  logic [`NATV_GPIO_W-1:0] gpio_in_i,
  output logic [`NATV_GPIO_W-1:0] gpio_out_o,
  output logic [`NATV_GPIO_W-1:0] gpio_oe_o
);

  localparam int GW = `NATV_GPIO_W;

  logic [GW-1:0]        dir_q;
  logic [GW-1:0]        out_q;
  logic [GW-1:0]        in_meta_q;
  logic [GW-1:0]        in_sync_q;
  logic [7:0]           s_offs;
  logic                 s_wr_en;
  natv_pkg::natv_data_t s_dir_wr;
  natv_pkg::natv_data_t s_out_wr;

  assign s_offs  = addr_i[7:0];
  // write lands on the edge where ready is seen
  assign s_wr_en = valid_i & ready_o & (|wstrb_i);

  assign s_dir_wr = natv_pkg::natv_strb_merge(natv_pkg::natv_data_t'(dir_q), wdata_i, wstrb_i);
  assign s_out_wr = natv_pkg::natv_strb_merge(natv_pkg::natv_data_t'(out_q), wdata_i, wstrb_i);

  always_ff @(posedge clk_i) begin
    in_meta_q <= gpio_in_i;
    in_sync_q <= in_meta_q;
  end

  // one-cycle ready pulse per request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ready_o <= 1'b0;
    end else begin
      ready_o <= valid_i & ~ready_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && !ready_o) begin
      case (s_offs)
        `NATV_GPIO_DIR: rdata_o <= natv_pkg::natv_data_t'(dir_q);
        `NATV_GPIO_OUT: rdata_o <= natv_pkg::natv_data_t'(out_q);
        `NATV_GPIO_IN:  rdata_o <= natv_pkg::natv_data_t'(in_sync_q);
        default:        rdata_o <= '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dir_q <= '0;
      out_q <= '0;
    end else if (s_wr_en) begin
      if (s_offs == `NATV_GPIO_DIR) begin
        dir_q <= s_dir_wr[GW-1:0];
      end
      if (s_offs == `NATV_GPIO_OUT) begin
        out_q <= s_out_wr[GW-1:0];
      end
    end
  end

  assign gpio_out_o = out_q;
  assign gpio_oe_o  = dir_q;

endmodule

`default_nettype wire

// ==== natv_timer.sv ====
// prescaled compare timer on the native bus
// CTRL: bit 0 enable, bit 1 irq enable
// PSC, CMP, CNT registers and STAT pending bit (write 1 to clear)

`timescale 1ns/100ps
`default_nettype none

`include "natv_params.svh"

module natv_timer (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 valid_i,
  input  natv_pkg::natv_addr_t addr_i,
  input  natv_pkg::natv_data_t wdata_i,
  input  natv_pkg::natv_strb_t wstrb_i,
  output logic                 ready_o,
  output natv_pkg::natv_data_t rdata_o,
  output logic                 irq_o
);

  logic [1:0]           ctrl_q;
  natv_pkg::natv_data_t psc_q;
  natv_pkg::natv_data_t cmp_q;
  natv_pkg::natv_data_t cnt_q;
  natv_pkg::natv_data_t div_q;
  logic                 pend_q;
  logic [7:0]           s_offs;
  logic                 s_wr_en;
  logic                 s_tick;
  logic                 s_hit;
  logic                 s_pend_clr;

  assign s_offs  = addr_i[7:0];
  assign s_wr_en = valid_i & ready_o & (|wstrb_i);

  // >= also catches a limit lowered below the running value
  assign s_tick = ctrl_q[0] & (div_q >= psc_q);
  assign s_hit  = s_tick & (cnt_q >= cmp_q);

  assign s_pend_clr = s_wr_en && (s_offs == `NATV_TIM_STAT) && wstrb_i[0] && wdata_i[0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ready_o <= 1'b0;
    end else begin
      ready_o <= valid_i & ~ready_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && !ready_o) begin
      case (s_offs)
        `NATV_TIM_CTRL: rdata_o <= {30'd0, ctrl_q};
        `NATV_TIM_PSC:  rdata_o <= psc_q;
        `NATV_TIM_CMP:  rdata_o <= cmp_q;
        `NATV_TIM_CNT:  rdata_o <= cnt_q;
        `NATV_TIM_STAT: rdata_o <= {31'd0, pend_q};
        default:        rdata_o <= '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_q <= '0;
      psc_q  <= '0;
      cmp_q  <= '0;
    end else if (s_wr_en) begin
      case (s_offs)
        `NATV_TIM_CTRL: begin
          if (wstrb_i[0]) begin
            ctrl_q <= wdata_i[1:0];
          end
        end
        `NATV_TIM_PSC: psc_q <= natv_pkg::natv_strb_merge(psc_q, wdata_i, wstrb_i);
        `NATV_TIM_CMP: cmp_q <= natv_pkg::natv_strb_merge(cmp_q, wdata_i, wstrb_i);
        default: ;
      endcase
    end
  end

  // prescaler, one tick every PSC+1 clocks
  always_ff @(posedge clk_i) begin
    if (rst_i || !ctrl_q[0] || s_tick) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  // bus load of CNT wins over a tick
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (s_wr_en && (s_offs == `NATV_TIM_CNT)) begin
      cnt_q <= natv_pkg::natv_strb_merge(cnt_q, wdata_i, wstrb_i);
    end else if (s_hit) begin
      cnt_q <= '0;
    end else if (s_tick) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // a new event beats a clear on the same edge
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q <= 1'b0;
    end else if (s_hit) begin
      pend_q <= 1'b1;
    end else if (s_pend_clr) begin
      pend_q <= 1'b0;
    end
  end

  assign irq_o = pend_q & ctrl_q[1];

endmodule

`default_nettype wire

// ==== natv_resp_mux.sv ====
// response merge for the native bus
// ORs peripheral ready, gates each rdata with its own ready
// answers decode misses with a fixed read value

`timescale 1ns/100ps
`default_nettype none

`include "natv_params.svh"

module natv_resp_mux (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 miss_valid_i,
  input  logic                 gpio_ready_i,
  input  natv_pkg::natv_data_t gpio_rdata_i,
  input  logic                 tim0_ready_i,
  input  natv_pkg::natv_data_t tim0_rdata_i,
  input  logic                 tim1_ready_i,
  input  natv_pkg::natv_data_t tim1_rdata_i,
  output logic                 nmi_ready_o,
  output natv_pkg::natv_data_t nmi_rdata_o
);

  localparam int DW = `NATV_DATA_W;

  logic miss_ready_q;

  // miss responder, same one-cycle timing as a peripheral
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      miss_ready_q <= 1'b0;
    end else begin
      miss_ready_q <= miss_valid_i & ~miss_ready_q;
    end
  end

  assign nmi_ready_o = gpio_ready_i | tim0_ready_i | tim1_ready_i | miss_ready_q;

  assign nmi_rdata_o = ({DW{gpio_ready_i}} & gpio_rdata_i) |
                       ({DW{tim0_ready_i}} & tim0_rdata_i) |
                       ({DW{tim1_ready_i}} & tim1_rdata_i) |
                       ({DW{miss_ready_q}} & `NATV_UNMAPPED_RDATA);

endmodule

`default_nettype wire

// ==== ip_natv_wrapper.sv ====
// native bus peripheral subsystem top level
// decoder, gpio block, two timers and response merge
// irq_o bit 0 from timer 0, bit 1 from timer 1

`timescale 1ns/100ps
`default_nettype none

`include "natv_params.svh"

module ip_natv_wrapper (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // nmi slave side
  input  logic                    nmi_valid_i,
  input  natv_pkg::natv_addr_t    nmi_addr_i,
  input  natv_pkg::natv_data_t    nmi_wdata_i,
  input  natv_pkg::natv_strb_t    nmi_wstrb_i,
  output logic                    nmi_ready_o,
  output natv_pkg::natv_data_t    nmi_rdata_o,
  // gpio pins
  input  logic [`NATV_GPIO_W-1:0] gpio_in_i,
  output logic [`NATV_GPIO_W-1:0] gpio_out_o,
  output logic [`NATV_GPIO_W-1:0] gpio_oe_o,
  output logic [1:0]              irq_o
);

  logic                 s_gpio_valid;
  logic                 s_tim0_valid;
  logic                 s_tim1_valid;
  logic                 s_miss_valid;
  logic                 s_gpio_ready;
  logic                 s_tim0_ready;
  logic                 s_tim1_ready;
  natv_pkg::natv_data_t s_gpio_rdata;
  natv_pkg::natv_data_t s_tim0_rdata;
  natv_pkg::natv_data_t s_tim1_rdata;

  natv_decode u_natv_decode (
    .nmi_valid_i (nmi_valid_i),
    .nmi_addr_i  (nmi_addr_i),
    .gpio_valid_o(s_gpio_valid),
    .tim0_valid_o(s_tim0_valid),
    .tim1_valid_o(s_tim1_valid),
    .miss_valid_o(s_miss_valid)
  );

  natv_gpio u_natv_gpio (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .valid_i   (s_gpio_valid),
    .addr_i    (nmi_addr_i),
    .wdata_i   (nmi_wdata_i),
    .wstrb_i   (nmi_wstrb_i),
    .ready_o   (s_gpio_ready),
    .rdata_o   (s_gpio_rdata),
    .gpio_in_i (gpio_in_i),
    .gpio_out_o(gpio_out_o),
    .gpio_oe_o (gpio_oe_o)
  );

  natv_timer u_natv_timer0 (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .valid_i(s_tim0_valid),
    .addr_i (nmi_addr_i),
    .wdata_i(nmi_wdata_i),
    .wstrb_i(nmi_wstrb_i),
    .ready_o(s_tim0_ready),
    .rdata_o(s_tim0_rdata),
    .irq_o  (irq_o[0])
  );

  natv_timer u_natv_timer1 (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .valid_i(s_tim1_valid),
    .addr_i (nmi_addr_i),
    .wdata_i(nmi_wdata_i),
    .wstrb_i(nmi_wstrb_i),
    .ready_o(s_tim1_ready),
    .rdata_o(s_tim1_rdata),
    .irq_o  (irq_o[1])
  );

  natv_resp_mux u_natv_resp_mux (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .miss_valid_i(s_miss_valid),
    .gpio_ready_i(s_gpio_ready),
    .gpio_rdata_i(s_gpio_rdata),
    .tim0_ready_i(s_tim0_ready),
    .tim0_rdata_i(s_tim0_rdata),
    .tim1_ready_i(s_tim1_ready),
    .tim1_rdata_i(s_tim1_rdata),
    .nmi_ready_o (nmi_ready_o),
    .nmi_rdata_o (nmi_rdata_o)
  );

endmodule

`default_nettype wire

// ==== ip_natv_asserts.sv ====
// bound checks for the native bus subsystem
// ready timing against valid, single ready pulse, one-hot decoder valids

`timescale 1ns/100ps
`default_nettype none

module ip_natv_asserts (
  input logic clk_i,
  input logic rst_i,
  input logic valid_i,
  input logic ready_i,
  input logic gpio_valid_i,
  input logic tim0_valid_i,
  input logic tim1_valid_i,
  input logic miss_valid_i
);

  int err_cnt = 0;

  // ready only answers a request seen in the cycle before
  ap_ready_has_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    ready_i |-> $past(valid_i))
    else begin
      $error("nmi ready without a valid in the previous cycle");
      err_cnt++;
    end

  ap_ready_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    ready_i |=> !ready_i)
    else begin
      $error("nmi ready high for two cycles in a row");
      err_cnt++;
    end

  ap_decode_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({gpio_valid_i, tim0_valid_i, tim1_valid_i, miss_valid_i}))
    else begin
      $error("more than one decoder valid is high");
      err_cnt++;
    end

  // a fresh request is answered on the next cycle
  ap_ready_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    (valid_i && !ready_i) |=> ready_i)
    else begin
      $error("nmi ready did not follow valid after one cycle");
      err_cnt++;
    end

endmodule

bind ip_natv_wrapper ip_natv_asserts u_ip_natv_asserts (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .valid_i     (nmi_valid_i),
  .ready_i     (nmi_ready_o),
  .gpio_valid_i(s_gpio_valid),
  .tim0_valid_i(s_tim0_valid),
  .tim1_valid_i(s_tim1_valid),
  .miss_valid_i(s_miss_valid)
);

`default_nettype wire

// ==== tb_ip_natv_wrapper.sv ====
// testbench for the native bus peripheral subsystem
// reads accesses and expected values from natv_cases.txt
// bus driver, gpio pin model, polling, irq checks, watchdog and summary

`timescale 1ns/100ps
`default_nettype none

`include "natv_params.svh"

module tb_ip_natv_wrapper;

  localparam int CLK_HALF   = 10;
  localparam int RST_CYCLES = 5;
  localparam int ACK_LIMIT  = 8;
  localparam int POLL_LIMIT = 200;

  logic                    clk_i;
  logic                    rst_i;
  logic                    nmi_valid_i;
  natv_pkg::natv_addr_t    nmi_addr_i;
  natv_pkg::natv_data_t    nmi_wdata_i;
  natv_pkg::natv_strb_t    nmi_wstrb_i;
  logic                    nmi_ready_o;
  natv_pkg::natv_data_t    nmi_rdata_o;
  logic [`NATV_GPIO_W-1:0] gpio_in_i;
  logic [`NATV_GPIO_W-1:0] gpio_out_o;
  logic [`NATV_GPIO_W-1:0] gpio_oe_o;
  logic [1:0]              irq_o;

  // case table, one entry per line of the cases file
  string       op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] mask_q[$];
  string       name_q[$];

  // expected pin state
  logic [`NATV_GPIO_W-1:0] dir_m;
  logic [`NATV_GPIO_W-1:0] out_m;
  logic [`NATV_GPIO_W-1:0] pins_m;

  integer seed;
  int     errs;
  int     pass_cnt;
  int     fail_cnt;
  int     cycle_cnt = 0;
  bit     loaded = 1'b0;

  ip_natv_wrapper UUT (.*);

  always #(CLK_HALF) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic bit is_gpio_reg(input logic [31:0] addr, input logic [7:0] offs);
    return (addr[31:24] == `NATV_REG_REGION) && (addr[15:8] == `NATV_GPIO_SLOT) &&
           (addr[7:0] == offs);
  endfunction

  task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH at %0t: %0s expected %h, got %h", $time, sig, exp, act);
      errs++;
    end
  endtask

  // one nmi access, started on a rising edge and ended one idle cycle after ready
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, output logic [31:0] rdata);
    int wait_cyc;
    wait_cyc = 0;
    rdata = '0;
    nmi_valid_i <= 1'b1;
    nmi_addr_i  <= addr;
    nmi_wdata_i <= wdata;
    nmi_wstrb_i <= strb;
    do begin
      @(posedge clk_i);
      wait_cyc++;
    end while (!nmi_ready_o && wait_cyc < ACK_LIMIT);
    nmi_valid_i <= 1'b0;
    nmi_wstrb_i <= '0;
    if (!nmi_ready_o) begin
      $display("ERROR at %0t: access to %h got no ready within %0d cycles",
               $time, addr, ACK_LIMIT);
      errs++;
    end else begin
      rdata = nmi_rdata_o;
      // valid is seen on the first edge, ready on the second
      if (wait_cyc != 2) begin
        $display("MISMATCH at %0t: nmi_ready_o latency expected 2, got %0d", $time, wait_cyc);
        errs++;
      end
    end
    @(posedge clk_i);
    if (nmi_ready_o) begin
      $display("ERROR at %0t: access to %h got a second ready pulse", $time, addr);
      errs++;
    end
    check_value("gpio_oe_o", dir_m, gpio_oe_o);
    check_value("gpio_out_o", out_m, gpio_out_o);
  endtask

  task automatic run_case(input int i);
    logic [31:0] rd;
    logic [31:0] exp;
    int          start;
    int          rnd;
    errs = 0;
    case (op_q[i])
      "W": begin
        if (is_gpio_reg(addr_q[i], `NATV_GPIO_DIR) && mask_q[i][0]) begin
          dir_m = data_q[i][`NATV_GPIO_W-1:0];
        end
        if (is_gpio_reg(addr_q[i], `NATV_GPIO_OUT) && mask_q[i][0]) begin
          out_m = data_q[i][`NATV_GPIO_W-1:0];
        end
        bus_access(addr_q[i], data_q[i], mask_q[i][3:0], rd);
      end
      "R": begin
        exp = data_q[i];
        // IN reads back the pins last driven
        if (is_gpio_reg(addr_q[i], `NATV_GPIO_IN)) begin
          exp = 32'(pins_m);
        end
        bus_access(addr_q[i], '0, '0, rd);
        check_value("nmi_rdata_o", exp & mask_q[i], rd & mask_q[i]);
      end
      "P": begin
        start = cycle_cnt;
        bus_access(addr_q[i], '0, '0, rd);
        while ((((rd ^ data_q[i]) & mask_q[i]) != 0) && (cycle_cnt - start < POLL_LIMIT)) begin
          bus_access(addr_q[i], '0, '0, rd);
        end
        if (((rd ^ data_q[i]) & mask_q[i]) != 0) begin
          $display("ERROR at %0t: register %h did not reach %h within %0d cycles",
                   $time, addr_q[i], data_q[i], POLL_LIMIT);
          errs++;
        end
      end
      "G": begin
        pins_m = data_q[i][`NATV_GPIO_W-1:0];
        if (mask_q[i] != 0) begin
          rnd    = $random(seed);
          pins_m = rnd[`NATV_GPIO_W-1:0] & mask_q[i][`NATV_GPIO_W-1:0];
        end
        gpio_in_i <= pins_m;
        // two-flop synchronizer plus one cycle of margin
        repeat (3) @(posedge clk_i);
      end
      "Q": begin
        check_value("irq_o", data_q[i] & mask_q[i], {30'd0, irq_o} & mask_q[i]);
      end
      default: begin
        $display("ERROR: case %0s has an unknown op %0s", name_q[i], op_q[i]);
        errs++;
      end
    endcase
    if (errs == 0) begin
      pass_cnt++;
      $display("test %0s ok", name_q[i]);
    end else begin
      fail_cnt++;
      $display("test %0s failed with %0d errors", name_q[i], errs);
    end
  endtask

  initial begin : main
    int          fd;
    int          n;
    string       line;
    string       op;
    string       name;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] m;
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    nmi_valid_i = 1'b0;
    nmi_addr_i  = '0;
    nmi_wdata_i = '0;
    nmi_wstrb_i = '0;
    gpio_in_i   = '0;
    dir_m       = '0;
    out_m       = '0;
    pins_m      = '0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    seed        = 32'h7cc09e87;
    fd = $fopen("natv_cases.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open natv_cases.txt");
      fail_cnt++;
    end else begin
      // comment lines never yield all five fields
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s %h %h %h %s", op, a, d, m, name);
        if (n == 5) begin
          op_q.push_back(op);
          addr_q.push_back(a);
          data_q.push_back(d);
          mask_q.push_back(m);
          name_q.push_back(name);
        end
      end
      $fclose(fd);
    end
    if (op_q.size() == 0) begin
      $display("ERROR: no test cases were read");
      fail_cnt++;
    end
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    foreach (op_q[i]) begin
      run_case(i);
    end
    if (UUT.u_ip_natv_asserts.err_cnt != 0) begin
      $display("ERROR: the bus checker saw %0d assertion failures",
               UUT.u_ip_natv_asserts.err_cnt);
      fail_cnt++;
    end
    $display("summary: %0d tests ok, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // every case fits in one poll bound
  initial begin : watchdog
    wait (loaded);
    #((op_q.size() * POLL_LIMIT + RST_CYCLES + 20) * 2 * CLK_HALF);
    $display("ERROR: the run timed out before all cases finished");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== natv_cases.txt ====
# op addr data mask name, all numbers in hex
# W mask is wstrb, R P mask selects bits, G mask draws random pins, Q compares irq_o
R 10000000 00000000 FFFFFFFF reset_gpio_dir
R 10002010 00000000 FFFFFFFF reset_tim0_stat
Q 0 00000000 00000003 reset_irq
W 10000000 000000A5 F gpio_dir_wr
R 10000000 000000A5 FFFFFFFF gpio_dir_rd
W 10000004 0000003C 1 gpio_out_wr
R 10000004 0000003C FFFFFFFF gpio_out_rd
W 10000004 0000FFC3 2 gpio_out_strb_hi
R 10000004 0000003C FFFFFFFF gpio_out_keep
W 10002004 11223344 F tim0_psc_wr
W 10002004 AABBCCDD 6 tim0_psc_strb
R 10002004 11BBCC44 FFFFFFFF tim0_psc_rd
W 10002008 00000011 F tim0_cmp_wr
W 10003008 00000022 F tim1_cmp_wr
R 10002008 00000011 FFFFFFFF tim0_cmp_iso
R 10003008 00000022 FFFFFFFF tim1_cmp_iso
G 0 0000005A 0 gpio_in_fixed
R 10000008 00000000 FFFFFFFF gpio_in_fixed_rd
G 0 00000000 FF gpio_in_rand
R 10000008 00000000 FFFFFFFF gpio_in_rand_rd
R 20000000 DEADBEEF FFFFFFFF unmapped_region_rd
R 10001000 DEADBEEF FFFFFFFF unused_slot_rd
W 20000004 000000FF F unmapped_region_wr
W 10001008 000000FF F unused_slot_wr
R 10000004 0000003C FFFFFFFF gpio_out_after_miss
R 10002008 00000011 FFFFFFFF tim0_cmp_after_miss
R 10003008 00000022 FFFFFFFF tim1_cmp_after_miss
W 10002004 00000001 F tim0_psc_small
W 10002008 00000003 F tim0_cmp_small
W 10002000 00000003 1 tim0_start
R 1000200C 00000000 FFFFFFFC tim0_cnt_bound
P 10002010 00000001 00000001 tim0_pending
Q 0 00000001 00000003 tim0_irq_on
W 10002000 00000002 1 tim0_stop
Q 0 00000001 00000003 tim0_irq_held
W 10002010 00000001 1 tim0_stat_clr
R 10002010 00000000 00000001 tim0_stat_rd
Q 0 00000000 00000003 tim0_irq_off
W 10002000 00000001 1 tim0_run_noirq
P 10002010 00000001 00000001 tim0_pending_again
Q 0 00000000 00000003 tim0_irq_masked
W 10002000 00000000 1 tim0_halt

// ==== list.f ====
+incdir+.
natv_pkg.sv
natv_decode.sv
natv_gpio.sv
natv_timer.sv
natv_resp_mux.sv
ip_natv_wrapper.sv
ip_natv_asserts.sv
tb_ip_natv_wrapper.sv

// ==== Bender.yml ====
package:
  name: natv_subsys

export_include_dirs:
  - .

sources:
  - natv_pkg.sv
  - natv_decode.sv
  - natv_gpio.sv
  - natv_timer.sv
  - natv_resp_mux.sv
  - ip_natv_wrapper.sv
  - target: test
    files:
      - ip_natv_asserts.sv
      - tb_ip_natv_wrapper.sv
